// ==== erx_cfg.sv ====
`timescale 1ns/100ps
module erx_cfg
   import erx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cfg_access,
   input  logic        cfg_write,
   input  logic [7:0]  cfg_addr,
   input  logic [31:0] cfg_wdata,
   input  mb_entry_t   mb_head,
   input  logic        mailbox_full,
   input  logic        mailbox_not_empty,
   output logic        cfg_rvalid,
   output logic [31:0] cfg_rdata,
   output logic        mb_pop,
   output logic [1:0]  remap_mode,
   output logic [11:0] remap_sel,
   output logic [11:0] remap_pattern,
   output logic [31:0] remap_base
);

   logic        wr_en;
   logic        rd_en;
   logic [31:0] rd_mux;

   assign wr_en  = cfg_access && cfg_write;
   assign rd_en  = cfg_access && !cfg_write;
   assign mb_pop = rd_en && (cfg_addr == REG_MB_LO) && mailbox_not_empty; // Head read first

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remap_mode    <= '0;
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
      end else if (wr_en) begin
         case (cfg_addr)
            REG_REMAP_MODE:    remap_mode    <= cfg_wdata[1:0];
            REG_REMAP_SEL:     remap_sel     <= cfg_wdata[11:0];
            REG_REMAP_PATTERN: remap_pattern <= cfg_wdata[11:0];
            REG_REMAP_BASE:    remap_base    <= cfg_wdata;
            default: ;                            // Read-only or unmapped
         endcase
      end
   end

   always_comb begin
      case (cfg_addr)
         REG_REMAP_MODE:    rd_mux = {30'b0, remap_mode};
         REG_REMAP_SEL:     rd_mux = {20'b0, remap_sel};
         REG_REMAP_PATTERN: rd_mux = {20'b0, remap_pattern};
         REG_REMAP_BASE:    rd_mux = remap_base;
         REG_MB_LO:         rd_mux = mb_head.data;
         REG_MB_HI:         rd_mux = mb_head.src_addr;
         REG_MB_STAT:       rd_mux = {30'b0, mailbox_full, mailbox_not_empty};
         default:           rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_rvalid <= 1'b0;
      end else begin
         cfg_rvalid <= rd_en;                     // One cycle read latency
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         cfg_rdata <= rd_mux;
      end
   end

endmodule

// ==== erx_core.sv ====
`timescale 1ns/100ps
module erx_core
   import erx_pkg::*;
#(
   parameter logic [11:0] ID          = 12'h800,
   parameter int          CH_DEPTH    = 8,
   parameter int          OUT_CREDITS = 4,
   parameter int          MB_DEPTH    = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rx_access,
   input  logic        rx_burst,
   input  erx_packet_t rx_packet,
   output logic        rx_wr_credit,
   output logic        rx_rd_credit,
   output logic        rx_rr_credit,
   output logic        rxwr_valid,
   output erx_packet_t rxwr_packet,
   input  logic        rxwr_credit,
   output logic        rxrd_valid,
   output erx_packet_t rxrd_packet,
   input  logic        rxrd_credit,
   output logic        rxrr_valid,
   output erx_packet_t rxrr_packet,
   input  logic        rxrr_credit,
   input  logic        cfg_access,
   input  logic        cfg_write,
   input  logic [7:0]  cfg_addr,
   input  logic [31:0] cfg_wdata,
   output logic        cfg_rvalid,
   output logic [31:0] cfg_rdata,
   output logic        mailbox_full,
   output logic        mailbox_not_empty
);

   localparam int PEND_W = $clog2(CH_DEPTH + 2);

   logic              prot_valid;
   chan_e             prot_class;
   erx_packet_t       prot_pkt;
   logic              rmp_valid;
   chan_e             rmp_class;
   erx_packet_t       rmp_pkt;
   logic [1:0]        remap_mode;
   logic [11:0]       remap_sel;
   logic [11:0]       remap_pattern;
   logic [31:0]       remap_base;
   logic [NUM_CH-1:0] ch_push;
   erx_packet_t       ch_pkt;
   logic              mb_push;
   mb_entry_t         mb_entry;
   mb_entry_t         mb_head;
   logic              mb_credit;
   logic              mb_pop;
   logic [NUM_CH-1:0] ch_credit_in;
   logic [NUM_CH-1:0] ch_valid;
   logic [NUM_CH-1:0] up_credit;
   erx_packet_t       ch_out_pkt [NUM_CH];
   logic [PEND_W-1:0] wr_pend;                    // Write credits owed after a clash

   erx_protocol erx_protocol (.clk(clk), .rst_n(rst_n), .rx_access(rx_access),
      .rx_burst(rx_burst), .rx_packet(rx_packet), .pkt_valid(prot_valid),
      .pkt_class(prot_class), .pkt(prot_pkt));

   erx_remap #(.ID(ID)) erx_remap (.clk(clk), .rst_n(rst_n), .in_valid(prot_valid),
      .in_class(prot_class), .in_pkt(prot_pkt), .remap_mode(remap_mode),
      .remap_sel(remap_sel), .remap_pattern(remap_pattern), .remap_base(remap_base),
      .out_valid(rmp_valid), .out_class(rmp_class), .out_pkt(rmp_pkt));

   erx_distributor #(.ID(ID)) erx_distributor (.clk(clk), .rst_n(rst_n),
      .in_valid(rmp_valid), .in_class(rmp_class), .in_pkt(rmp_pkt), .ch_push(ch_push),
      .ch_pkt(ch_pkt), .mb_push(mb_push), .mb_entry(mb_entry), .mb_credit(mb_credit));

   erx_mailbox #(.MB_DEPTH(MB_DEPTH)) erx_mailbox (.clk(clk), .rst_n(rst_n),
      .push(mb_push), .entry(mb_entry), .pop(mb_pop), .head(mb_head),
      .mailbox_full(mailbox_full), .mailbox_not_empty(mailbox_not_empty));

   erx_cfg erx_cfg (.clk(clk), .rst_n(rst_n), .cfg_access(cfg_access),
      .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .mb_head(mb_head), .mailbox_full(mailbox_full),
      .mailbox_not_empty(mailbox_not_empty), .cfg_rvalid(cfg_rvalid),
      .cfg_rdata(cfg_rdata), .mb_pop(mb_pop), .remap_mode(remap_mode),
      .remap_sel(remap_sel), .remap_pattern(remap_pattern), .remap_base(remap_base));

   assign ch_credit_in = {rxrr_credit, rxrd_credit, rxwr_credit}; // Indexed by chan_e

   for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
      rx_channel #(.CH_DEPTH(CH_DEPTH), .OUT_CREDITS(OUT_CREDITS)) rx_channel (
         .clk(clk), .rst_n(rst_n), .push(ch_push[i]), .push_pkt(ch_pkt),
         .out_credit(ch_credit_in[i]), .out_valid(ch_valid[i]),
         .out_pkt(ch_out_pkt[i]), .up_credit(up_credit[i]));
   end

   assign rxwr_valid   = ch_valid[CH_WR];
   assign rxwr_packet  = ch_out_pkt[CH_WR];
   assign rxrd_valid   = ch_valid[CH_RD];
   assign rxrd_packet  = ch_out_pkt[CH_RD];
   assign rxrr_valid   = ch_valid[CH_RR];
   assign rxrr_packet  = ch_out_pkt[CH_RR];
   assign rx_rd_credit = up_credit[CH_RD];
   assign rx_rr_credit = up_credit[CH_RR];

   // Channel and mailbox credits share one wire, a clash is paid next cycle
   assign rx_wr_credit = up_credit[CH_WR] || mb_credit || (wr_pend != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_pend <= '0;
      end else begin
         wr_pend <= wr_pend + PEND_W'(up_credit[CH_WR]) + PEND_W'(mb_credit)
                    - PEND_W'(rx_wr_credit);
      end
   end

endmodule

// ==== erx_core_tb.sv ====
`timescale 1ns/100ps
module erx_core_tb
   import erx_pkg::*;
();

   localparam logic [11:0] ID          = 12'h810;
   localparam int          CH_DEPTH    = 8;
   localparam int          OUT_CREDITS = 4;
   localparam int          MB_DEPTH    = 4;
   localparam int          SEED        = 67430;
   localparam int          WAIT_LIMIT  = 400;     // Cycles per wait loop

   logic        clk;
   logic        rst_n;
   logic        rx_access;
   logic        rx_burst;
   erx_packet_t rx_packet;
   logic        rx_wr_credit;
   logic        rx_rd_credit;
   logic        rx_rr_credit;
   logic        rxwr_valid;
   erx_packet_t rxwr_packet;
   logic        rxwr_credit;
   logic        rxrd_valid;
   erx_packet_t rxrd_packet;
   logic        rxrd_credit;
   logic        rxrr_valid;
   erx_packet_t rxrr_packet;
   logic        rxrr_credit;
   logic        cfg_access;
   logic        cfg_write;
   logic [7:0]  cfg_addr;
   logic [31:0] cfg_wdata;
   logic        cfg_rvalid;
   logic [31:0] cfg_rdata;
   logic        mailbox_full;
   logic        mailbox_not_empty;

   erx_packet_t exp_q [NUM_CH][$];                // Expected per channel, send order
   mb_entry_t   mb_q [$];                         // Expected mailbox contents
   erx_packet_t last_beat;                        // Burst base, before remap
   bit          have_last;
   int          snd_cred [NUM_CH];                // Sender credits per channel
   int          owed [NUM_CH];                    // Downstream credits not yet returned
   bit          withhold;                         // Consumer holds its credits
   int          errors;
   int          timeouts;
   int          consumed;                         // Packets taken off the channels
   int          mb_writes;                        // Mailbox writes, dropped ones too
   int          up_total;                         // Upstream credit pulses seen
   bit          rd_seen;
   logic [31:0] rd_word;
   logic [1:0]  m_mode;                           // Model copy of remap registers
   logic [11:0] m_sel;
   logic [11:0] m_pat;
   logic [31:0] m_base;
   string       ch_names [NUM_CH] = '{"write", "read", "read response"};

   tb_clock clk_gen (.clk(clk));

   erx_core #(.ID(ID), .CH_DEPTH(CH_DEPTH), .OUT_CREDITS(OUT_CREDITS),
      .MB_DEPTH(MB_DEPTH)) erx_core_inst (.*);

   task automatic compare_packet(input erx_packet_t got, input erx_packet_t exp,
                                 input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s packet %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("Timeout at %0t: gave up waiting for %s", $time, what);
   endtask

   // Class from the write flag and ctrlmode, after burst expansion
   function automatic chan_e class_of(erx_packet_t p);
      if (!p.write) begin
         return CH_RD;
      end
      return p.ctrlmode[CTRL_RR_BIT] ? CH_RR : CH_WR;
   endfunction

   function automatic erx_packet_t expand_beat(erx_packet_t raw);
      erx_packet_t e;
      e          = last_beat;                     // Header of previous beat
      e.dst_addr = last_beat.dst_addr + BURST_STRIDE;
      e.data     = raw.data;
      return e;
   endfunction

   function automatic logic [31:0] remapped(logic [31:0] a, chan_e c);
      logic [31:0] r;
      r = a;
      if (c != CH_RR && a[31:20] != ID) begin    // Own region is never moved
         if (m_mode == 2'd1) begin
            r[31:20] = (a[31:20] & ~m_sel) | (m_pat & m_sel);
         end else if (m_mode == 2'd2) begin
            r = a + m_base;
         end
      end
      return r;
   endfunction

   // Kind follows chan_e numbering
   function automatic erx_packet_t rand_pkt(int kind);
      erx_packet_t p;
      p.write                 = (kind != int'(CH_RD));
      p.datamode              = 2'($urandom);
      p.ctrlmode              = 5'($urandom);
      p.ctrlmode[CTRL_RR_BIT] = (kind == int'(CH_RR));
      p.dst_addr              = $urandom;
      p.data                  = $urandom;
      p.src_addr              = $urandom;
      if (p.dst_addr[31:20] == ID) begin
         p.dst_addr[31] = ~p.dst_addr[31];        // Stay out of own region
      end
      return p;
   endfunction

   // One clock: check outputs, count credits, return downstream credits
   task automatic cycle();
      logic [NUM_CH-1:0] vld;
      logic [NUM_CH-1:0] up;
      logic [NUM_CH-1:0] ret;
      erx_packet_t       got [NUM_CH];
      erx_packet_t       exp;
      @(posedge clk);
      #1;
      vld        = {rxrr_valid, rxrd_valid, rxwr_valid};
      up         = {rx_rr_credit, rx_rd_credit, rx_wr_credit};
      got[CH_WR] = rxwr_packet;
      got[CH_RD] = rxrd_packet;
      got[CH_RR] = rxrr_packet;
      for (int i = 0; i < NUM_CH; i++) begin
         if (vld[i]) begin
            consumed++;
            owed[i]++;
            if (exp_q[i].size() == 0) begin
               errors++;
               $display("Packet on the %s channel at %0t that was never sent", ch_names[i],
                        $time);
            end else begin
               exp = exp_q[i].pop_front();
               compare_packet(got[i], exp, ch_names[i]);
            end
            if (owed[i] > OUT_CREDITS) begin
               errors++;
               $display("The %s channel sent without a downstream credit at %0t",
                        ch_names[i], $time);
            end
         end
         if (up[i]) begin
            up_total++;
            snd_cred[i]++;
            if (snd_cred[i] > CH_DEPTH) begin
               errors++;
               $display("More %s credits returned than were used at %0t", ch_names[i],
                        $time);
            end
         end
         ret[i] = !withhold && (owed[i] > 0);
         if (ret[i]) begin
            owed[i]--;
         end
      end
      if (cfg_rvalid) begin
         rd_seen = 1'b1;
         rd_word = cfg_rdata;
      end
      rxwr_credit = ret[CH_WR];
      rxrd_credit = ret[CH_RD];
      rxrr_credit = ret[CH_RR];
   endtask

   task automatic idle(input int n);
      repeat (n) cycle();
   endtask

   // Sends one beat after a credit for its class is held, updates the model
   task automatic send_pkt(input erx_packet_t raw, input bit burst);
      erx_packet_t eff;
      erx_packet_t out;
      chan_e       cls;
      int          n;
      eff = burst ? expand_beat(raw) : raw;
      cls = class_of(eff);
      n   = 0;
      while (snd_cred[cls] == 0 && timeouts == 0) begin
         cycle();
         n++;
         if (n > WAIT_LIMIT) begin
            report_timeout("a sender credit");
         end
      end
      if (timeouts == 0) begin
         rx_access = 1'b1;
         rx_burst  = burst;
         rx_packet = raw;                         // Header fields of a beat are ignored
         snd_cred[cls]--;
         last_beat    = eff;
         have_last    = 1'b1;
         out          = eff;
         out.dst_addr = remapped(eff.dst_addr, cls);
         if (cls == CH_WR && out.dst_addr[31:20] == ID && out.dst_addr[19:0] == MB_OFFSET) begin
            mb_writes++;
            if (mb_q.size() < MB_DEPTH) begin
               mb_q.push_back('{src_addr: out.src_addr, data: out.data});
            end
         end else begin
            exp_q[cls].push_back(out);
         end
         cycle();
         rx_access = 1'b0;
         rx_burst  = 1'b0;
      end
   endtask

   task automatic cfg_write_reg(input logic [7:0] addr, input logic [31:0] data);
      cfg_access = 1'b1;
      cfg_write  = 1'b1;
      cfg_addr   = addr;
      cfg_wdata  = data;
      case (addr)
         REG_REMAP_MODE:    m_mode = data[1:0];
         REG_REMAP_SEL:     m_sel  = data[11:0];
         REG_REMAP_PATTERN: m_pat  = data[11:0];
         REG_REMAP_BASE:    m_base = data;
         default: ;
      endcase
      cycle();
      cfg_access = 1'b0;
      cfg_write  = 1'b0;
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp, input string what);
      int n;
      rd_seen    = 1'b0;
      cfg_access = 1'b1;
      cfg_write  = 1'b0;
      cfg_addr   = addr;
      cycle();
      cfg_access = 1'b0;
      n          = 0;
      while (!rd_seen && timeouts == 0) begin
         cycle();
         n++;
         if (n > WAIT_LIMIT) begin
            report_timeout("cfg_rvalid");
         end
      end
      if (rd_seen) begin
         compare_word(rd_word, exp, what);
      end
   endtask

   // Idle once every sender credit is back and nothing is expected
   task automatic wait_idle();
      int n;
      bit busy;
      n    = 0;
      busy = 1'b1;
      while (busy && timeouts == 0) begin
         busy = 1'b0;
         for (int i = 0; i < NUM_CH; i++) begin
            if (exp_q[i].size() != 0 || snd_cred[i] != CH_DEPTH) begin
               busy = 1'b1;
            end
         end
         if (busy) begin
            cycle();
            n++;
            if (n > WAIT_LIMIT) begin
               report_timeout("the channels to drain");
            end
         end
      end
   endtask

   task automatic random_stream(input int count, input bit allow_burst);
      bit burst;
      for (int k = 0; k < count; k++) begin
         burst = allow_burst && have_last && ($urandom % 4 == 0);
         send_pkt(rand_pkt(int'($urandom % 3)), burst);
         if ($urandom % 3 == 0) begin
            idle(int'($urandom % 3));             // Gaps between packets
         end
      end
   endtask

   task automatic mailbox_write();
      erx_packet_t p;
      p          = rand_pkt(int'(CH_WR));
      p.dst_addr = {ID, MB_OFFSET};
      send_pkt(p, 1'b0);
   endtask

   initial begin
      logic [11:0] sel;
      logic [11:0] pat;
      logic [31:0] base;
      mb_entry_t   e;
      void'($urandom(SEED));
      rst_n       = 1'b0;
      rx_access   = 1'b0;
      rx_burst    = 1'b0;
      rx_packet   = '0;
      rxwr_credit = 1'b0;
      rxrd_credit = 1'b0;
      rxrr_credit = 1'b0;
      cfg_access  = 1'b0;
      cfg_write   = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      have_last   = 1'b0;
      last_beat   = '0;
      withhold    = 1'b0;
      errors      = 0;
      timeouts    = 0;
      consumed    = 0;
      mb_writes   = 0;
      up_total    = 0;
      rd_seen     = 1'b0;
      rd_word     = '0;
      m_mode      = '0;
      m_sel       = '0;
      m_pat       = '0;
      m_base      = '0;
      for (int i = 0; i < NUM_CH; i++) begin
         snd_cred[i] = CH_DEPTH;
         owed[i]     = 0;
      end
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;

      repeat (8) begin                            // Quiet after reset
         cycle();
         compare_flag(rxwr_valid | rxrd_valid | rxrr_valid, 1'b0, "valid after reset");
         compare_flag(rx_wr_credit | rx_rd_credit | rx_rr_credit, 1'b0, "credit after reset");
         compare_flag(cfg_rvalid, 1'b0, "cfg_rvalid after reset");
         compare_flag(mailbox_full, 1'b0, "mailbox_full after reset");
         compare_flag(mailbox_not_empty, 1'b0, "mailbox_not_empty after reset");
      end
      check_reg(REG_REMAP_MODE, 32'h0, "remap mode after reset");
      check_reg(REG_REMAP_SEL, 32'h0, "remap select after reset");
      check_reg(REG_REMAP_PATTERN, 32'h0, "remap pattern after reset");
      check_reg(REG_REMAP_BASE, 32'h0, "remap base after reset");

      random_stream(60, 1'b1);                    // Mixed classes, mode 0
      for (int b = 0; b < 3; b++) begin           // Explicit burst trains
         send_pkt(rand_pkt(b), 1'b0);
         for (int k = 0; k < 4; k++) begin
            send_pkt(rand_pkt(b), 1'b1);
         end
      end
      wait_idle();

      mailbox_write();
      wait_idle();
      compare_flag(mailbox_not_empty, 1'b1, "mailbox_not_empty after one write");
      compare_flag(mailbox_full, 1'b0, "mailbox_full after one write");
      for (int k = 1; k < MB_DEPTH; k++) begin
         mailbox_write();
      end
      wait_idle();
      compare_flag(mailbox_full, 1'b1, "mailbox_full at depth");
      mailbox_write();                            // These two are dropped
      mailbox_write();
      wait_idle();
      check_reg(REG_MB_STAT, 32'h3, "mailbox status when full");
      while (mb_q.size() > 0 && timeouts == 0) begin
         e = mb_q.pop_front();
         check_reg(REG_MB_HI, e.src_addr, "mailbox source");
         check_reg(REG_MB_LO, e.data, "mailbox data");
      end
      check_reg(REG_MB_STAT, 32'h0, "mailbox status after reads");
      compare_flag(mailbox_not_empty, 1'b0, "mailbox_not_empty after reads");

      sel  = 12'($urandom);
      pat  = 12'($urandom);
      base = $urandom;
      cfg_write_reg(REG_REMAP_SEL, {20'b0, sel});
      cfg_write_reg(REG_REMAP_PATTERN, {20'b0, pat});
      cfg_write_reg(REG_REMAP_MODE, 32'd1);
      check_reg(REG_REMAP_SEL, {20'b0, sel}, "remap select");
      check_reg(REG_REMAP_PATTERN, {20'b0, pat}, "remap pattern");
      random_stream(30, 1'b0);
      wait_idle();
      cfg_write_reg(REG_REMAP_BASE, base);
      cfg_write_reg(REG_REMAP_MODE, 32'd2);
      check_reg(REG_REMAP_BASE, base, "remap base");
      random_stream(30, 1'b0);
      wait_idle();
      cfg_write_reg(REG_REMAP_MODE, 32'd0);

      withhold = 1'b1;                            // Consumer stops returning credits
      for (int k = 0; k < 10; k++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            send_pkt(rand_pkt(c), 1'b0);
         end
      end
      idle(20);
      for (int c = 0; c < NUM_CH; c++) begin
         if (owed[c] != OUT_CREDITS) begin
            errors++;
            $display("Fail at %0t: %s channel sent %0d packets without credits, expected %0d",
                     $time, ch_names[c], owed[c], OUT_CREDITS);
         end
      end
      withhold = 1'b0;
      wait_idle();
      idle(4);
      compare_word(32'(up_total), 32'(consumed + mb_writes), "upstream credit total");

      $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== erx_distributor.sv ====
`timescale 1ns/100ps
module erx_distributor
   import erx_pkg::*;
#(
   parameter logic [11:0] ID = 12'h800
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid,
   input  chan_e             in_class,
   input  erx_packet_t       in_pkt,
   output logic [NUM_CH-1:0] ch_push,
   output erx_packet_t       ch_pkt,
   output logic              mb_push,
   output mb_entry_t         mb_entry,
   output logic              mb_credit
);

   logic mb_hit;

   // Write to own region at the mailbox offset
   assign mb_hit = in_valid && (in_class == CH_WR) &&
                   (in_pkt.dst_addr[31:20] == ID) &&
                   (in_pkt.dst_addr[19:0] == MB_OFFSET);

   always_comb begin
      ch_push = '0;
      if (in_valid && !mb_hit) begin
         ch_push[in_class] = 1'b1;                // One-hot by class
      end
   end

   assign ch_pkt            = in_pkt;             // Shared bus with push as the select
   assign mb_push           = mb_hit;
   assign mb_entry.src_addr = in_pkt.src_addr;
   assign mb_entry.data     = in_pkt.data;

   // Sender's write credit comes back even if the mailbox drops it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mb_credit <= 1'b0;
      end else begin
         mb_credit <= mb_hit;
      end
   end

   // Each packet lands in exactly one place
   a_one_dest : assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> $onehot({ch_push, mb_push}));

endmodule

// ==== erx_mailbox.sv ====
`timescale 1ns/100ps
module erx_mailbox
   import erx_pkg::*;
#(
   parameter int MB_DEPTH = 4
) (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      push,
   input  mb_entry_t entry,
   input  logic      pop,
   output mb_entry_t head,
   output logic      mailbox_full,
   output logic      mailbox_not_empty
);

   logic q_push;
   logic q_empty;
   logic q_full;

   assign q_push = push && !q_full;               // Write to a full mailbox is lost

   rx_queue #(
      .T     (mb_entry_t),
      .DEPTH (MB_DEPTH)
   ) mb_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (q_push),
      .push_data (entry),
      .pop       (pop),
      .head      (head),
      .empty     (q_empty),
      .full      (q_full)
   );

   // Queue flags are flops, valid the cycle after push or pop
   assign mailbox_full      = q_full;
   assign mailbox_not_empty = !q_empty;

endmodule

// ==== erx_pkg.sv ====
package erx_pkg;

   // Mesh packet as it travels on the link, MSB first
   typedef struct packed {
      logic        write;                         // Write flag
      logic [1:0]  datamode;                      // Transfer size
      logic [4:0]  ctrlmode;                      // Control bits
      logic [31:0] dst_addr;                      // Destination address
      logic [31:0] data;                          // Payload word
      logic [31:0] src_addr;                      // Source / return address
   } erx_packet_t;

   // Mailbox word pair
   typedef struct packed {
      logic [31:0] src_addr;                      // Upper word
      logic [31:0] data;                          // Lower word
   } mb_entry_t;

   // Output channel index
   typedef enum logic [1:0] {
      CH_WR = 2'd0,
      CH_RD = 2'd1,
      CH_RR = 2'd2
   } chan_e;

   localparam int NUM_CH      = 3;                // Write, read, read response
   localparam int CTRL_RR_BIT = 4;                // ctrlmode bit for read response

   localparam logic [19:0] MB_OFFSET = 20'hF0320; // Mailbox low address in own region

   // Config space, byte offsets
   localparam logic [7:0] REG_REMAP_MODE    = 8'h00;
   localparam logic [7:0] REG_REMAP_SEL     = 8'h04;
   localparam logic [7:0] REG_REMAP_PATTERN = 8'h08;
   localparam logic [7:0] REG_REMAP_BASE    = 8'h0C;
   localparam logic [7:0] REG_MB_LO         = 8'h10; // Read pops mailbox
   localparam logic [7:0] REG_MB_HI         = 8'h14;
   localparam logic [7:0] REG_MB_STAT       = 8'h18; // {full, not_empty}

   localparam logic [31:0] BURST_STRIDE = 32'd8;  // Double word per beat

endpackage

// ==== erx_protocol.sv ====
`timescale 1ns/100ps
module erx_protocol
   import erx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rx_access,
   input  logic        rx_burst,
   input  erx_packet_t rx_packet,
   output logic        pkt_valid,
   output chan_e       pkt_class,
   output erx_packet_t pkt
);

   erx_packet_t nxt_pkt;
   chan_e       nxt_class;
   logic        seen_pkt;                         // Any packet since reset

   // Burst beats take the header of the last beat
   always_comb begin
      nxt_pkt = rx_packet;
      if (rx_burst) begin
         nxt_pkt          = pkt;                  // Last registered beat
         nxt_pkt.dst_addr = pkt.dst_addr + BURST_STRIDE;
         nxt_pkt.data     = rx_packet.data;       // Only data is fresh
      end
   end

   always_comb begin
      if (!nxt_pkt.write) begin
         nxt_class = CH_RD;
      end else if (nxt_pkt.ctrlmode[CTRL_RR_BIT]) begin
         nxt_class = CH_RR;                       // Write carrying read data
      end else begin
         nxt_class = CH_WR;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_valid <= 1'b0;
         pkt_class <= CH_WR;
         seen_pkt  <= 1'b0;
      end else begin
         pkt_valid <= rx_access;
         if (rx_access) begin
            pkt_class <= nxt_class;
            seen_pkt  <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_access) begin
         pkt <= nxt_pkt;                          // Also the burst base
      end
   end

   a_burst_has_base : assert property (@(posedge clk) disable iff (!rst_n)
      (rx_access && rx_burst) |-> seen_pkt);

endmodule

// ==== erx_remap.sv ====
`timescale 1ns/100ps
module erx_remap
   import erx_pkg::*;
#(
   parameter logic [11:0] ID = 12'h800
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        in_valid,
   input  chan_e       in_class,
   input  erx_packet_t in_pkt,
   input  logic [1:0]  remap_mode,
   input  logic [11:0] remap_sel,
   input  logic [11:0] remap_pattern,
   input  logic [31:0] remap_base,
   output logic        out_valid,
   output chan_e       out_class,
   output erx_packet_t out_pkt
);

   logic [31:0] addr_in;
   logic [31:0] addr_out;
   logic        own_region;                       // Local registers and mailbox
   erx_packet_t nxt_pkt;

   assign addr_in    = in_pkt.dst_addr;
   assign own_region = (addr_in[31:20] == ID);

   always_comb begin
      case (remap_mode)
         2'd1:    addr_out = {(addr_in[31:20] & ~remap_sel) | (remap_pattern & remap_sel),
                              addr_in[19:0]};     // Static bit replace
         2'd2:    addr_out = addr_in + remap_base; // Offset remap
         default: addr_out = addr_in;             // Modes 0 and 3 pass
      endcase
   end

   // Read responses and own region keep their address
   always_comb begin
      nxt_pkt = in_pkt;
      if (in_class != CH_RR && !own_region) begin
         nxt_pkt.dst_addr = addr_out;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         out_class <= CH_WR;
      end else begin
         out_valid <= in_valid;
         if (in_valid) begin
            out_class <= in_class;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         out_pkt <= nxt_pkt;
      end
   end

endmodule

// ==== flist.f ====
erx_pkg.sv
rx_queue.sv
erx_protocol.sv
erx_remap.sv
erx_cfg.sv
erx_mailbox.sv
erx_distributor.sv
rx_channel.sv
erx_core.sv
tb_clock.sv
erx_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the erx_core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module erx_core_tb -o erx_core_sim
status=0
./obj_dir/erx_core_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TESTBENCH FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// ==== rx_channel.sv ====
`timescale 1ns/100ps
module rx_channel
   import erx_pkg::*;
#(
   parameter int CH_DEPTH    = 8,
   parameter int OUT_CREDITS = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        push,
   input  erx_packet_t push_pkt,
   input  logic        out_credit,
   output logic        out_valid,
   output erx_packet_t out_pkt,
   output logic        up_credit
);

   localparam int CW = $clog2(OUT_CREDITS + 1);

   logic [CW-1:0] credits;                        // Downstream credits held
   logic          send;
   logic          bypass;                         // Empty queue, straight to output
   logic          q_push;
   logic          q_pop;
   logic          q_empty;
   logic          q_full;
   erx_packet_t   q_head;

   assign send   = (credits != '0) && (!q_empty || push);
   assign bypass = send && q_empty;
   assign q_pop  = send && !q_empty;
   assign q_push = push && !bypass;

   rx_queue #(
      .T     (erx_packet_t),
      .DEPTH (CH_DEPTH)
   ) ch_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (q_push),
      .push_data (push_pkt),
      .pop       (q_pop),
      .head      (q_head),
      .empty     (q_empty),
      .full      (q_full)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits   <= CW'(OUT_CREDITS);
         out_valid <= 1'b0;
         up_credit <= 1'b0;
      end else begin
         credits   <= credits + CW'(out_credit) - CW'(send);
         out_valid <= send;                       // Single-cycle pulse
         up_credit <= send;                       // Slot freed upstream
      end
   end

   always_ff @(posedge clk) begin
      if (send) begin
         out_pkt <= bypass ? push_pkt : q_head;
      end
   end

   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      q_push |-> !q_full);
   a_credit_max : assert property (@(posedge clk) disable iff (!rst_n)
      credits <= CW'(OUT_CREDITS));

endmodule

// ==== rx_queue.sv ====
`timescale 1ns/100ps
module rx_queue #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 8
) (
   input  logic clk,
   input  logic rst_n,
   input  logic push,
   input  T     push_data,
   input  logic pop,
   output T     head,
   output logic empty,
   output logic full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;                          // Occupancy
   logic [CW-1:0] count_nxt;
   logic          do_push;
   logic          do_pop;

   assign do_pop    = pop && !empty;
   assign do_push   = push && (!full || do_pop); // Full but popping is fine
   assign count_nxt = count + CW'(do_push) - CW'(do_pop);
   assign head      = mem[rd_ptr];               // Show-ahead read

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         empty  <= 1'b1;
         full   <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at DEPTH
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count_nxt;
         empty <= (count_nxt == '0);              // Flags from next count
         full  <= (count_nxt == CW'(DEPTH));
      end
   end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps
module tb_clock #(
   parameter int HALF_PERIOD = 2                  // 4 ns period
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always begin
      #(HALF_PERIOD) clk = ~clk;
   end

endmodule
